/* rtl/l15_adapter_pkg.sv */
// shared definitions for the cache to L1.5 adapter
// widths, depths, request and return encodings, packet structs, byte swap

package l15_adapter_pkg;

  //////////////////////////////////////////////////
  // widths and depths
  //////////////////////////////////////////////////

  localparam int unsigned paddr_w         = 40;
  localparam int unsigned l15_way_w       = 2;
  // tid doubles as transaction id so several requests can be in flight
  localparam int unsigned l15_tid_w       = 2;
  localparam int unsigned inv_idx_w       = 16;
  localparam int unsigned req_fifo_depth  = 2;
  localparam int unsigned rtrn_fifo_depth = 2;

  // L1.5 size field, full line for cacheable ifills, 4 bytes for io space
  localparam logic [2:0] l15_size_4b   = 3'b010;
  localparam logic [2:0] l15_size_line = 3'b111;

  //////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////

  typedef enum logic [4:0] {
    l15_load_rq  = 5'b00000,
    l15_store_rq = 5'b00001,
    l15_imiss_rq = 5'b10000
  } l15_rqtype_e;

  typedef enum logic [3:0] {
    l15_load_ret  = 4'b0000,
    l15_ifill_ret = 4'b0001,
    l15_evict_req = 4'b0011,
    l15_st_ack    = 4'b0100
  } l15_rtntype_e;

  typedef enum logic [1:0] {
    dcache_load_req  = 2'b00,
    dcache_store_req = 2'b01
  } dcache_req_e;

  typedef enum logic [1:0] {
    icache_ifill_ack = 2'b00,
    icache_inv_req   = 2'b01
  } icache_rtrn_e;

  typedef enum logic [1:0] {
    dcache_load_ack  = 2'b00,
    dcache_store_ack = 2'b01,
    dcache_inv_req   = 2'b10
  } dcache_rtrn_e;

  //////////////////////////////////////////////////
  // packets
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [inv_idx_w-1:0] idx;
    logic [l15_way_w-1:0] way;
    logic                 vld;
    // all ways of the indexed set
    logic                 all;
  } cache_inv_t;

  typedef struct packed {
    logic                 nc;
    logic [l15_way_w-1:0] way;
    logic [l15_tid_w-1:0] tid;
    logic [paddr_w-1:0]   paddr;
  } icache_req_t;

  typedef struct packed {
    dcache_req_e          rtype;
    logic [2:0]           size;
    logic                 nc;
    logic [l15_way_w-1:0] way;
    logic [l15_tid_w-1:0] tid;
    logic [paddr_w-1:0]   paddr;
    logic [63:0]          data;
  } dcache_req_t;

  typedef struct packed {
    logic                 val;
    l15_rqtype_e          rqtype;
    logic                 nc;
    logic [2:0]           size;
    logic [l15_tid_w-1:0] tid;
    logic [l15_way_w-1:0] way;
    logic [paddr_w-1:0]   address;
    logic [63:0]          data;
  } l15_req_t;

  typedef struct packed {
    logic                 val;
    l15_rtntype_e         returntype;
    logic [l15_tid_w-1:0] tid;
    logic [63:0]          data_0;
    logic [63:0]          data_1;
    logic [63:0]          data_2;
    logic [63:0]          data_3;
    logic [11:0]          inval_address_15_4;
    logic [l15_way_w-1:0] inval_way;
    logic                 inval_icache_inval;
    logic                 inval_icache_all_way;
    logic                 inval_dcache_inval;
    logic                 inval_dcache_all_way;
  } l15_rtrn_t;

  typedef struct packed {
    icache_rtrn_e         rtype;
    logic [l15_tid_w-1:0] tid;
    cache_inv_t           inv;
    logic [255:0]         data;
  } icache_rtrn_t;

  typedef struct packed {
    dcache_rtrn_e         rtype;
    logic [l15_tid_w-1:0] tid;
    cache_inv_t           inv;
    logic [127:0]         data;
  } dcache_rtrn_t;

  // caches are little endian, L1.5 is big endian
  function automatic logic [63:0] swap_bytes64(input logic [63:0] word);
    logic [63:0] swapped;
    for (int b = 0; b < 8; b++) begin
      swapped[8*b +: 8] = word[8*(7-b) +: 8];
    end
    return swapped;
  endfunction

endpackage

/* rtl/l15_fifo.sv */
// small circular-buffer FIFO with a type parameter
// serves both request queues and the return queue

`timescale 1ns/100ps

module l15_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned depth     = l15_adapter_pkg::req_fifo_depth
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     push_i,
  input  payload_t data_i,
  output logic     full_o,
  output logic     empty_o,
  output payload_t data_o,
  input  logic     pop_i
);

  // one pointer bit minimum so depth 1 still elaborates
  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_w = $clog2(depth + 1);

  payload_t         mem [depth];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] cnt_q;

  assign full_o  = (cnt_q == cnt_w'(depth));
  assign empty_o = (cnt_q == '0);
  // head shown without a register stage
  assign data_o  = mem[rd_ptr_q];

  // pointers and fill count
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      if (push_i && !pop_i) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!push_i && pop_i) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  // the producer must respect full, the consumer must respect empty
  no_push_full: assert property (@(posedge clk_i) disable iff (reset_i) full_o |-> !push_i)
    else $error("l15_fifo: push while full");
  no_pop_empty: assert property (@(posedge clk_i) disable iff (reset_i) empty_o |-> !pop_i)
    else $error("l15_fifo: pop while empty");

endmodule

/* rtl/l15_req_arbiter.sv */
// round-robin lock-in arbiter over the icache and dcache request queues
// plus the encoder for the outgoing L1.5 request packet

`timescale 1ns/100ps

module l15_req_arbiter (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          icache_vld_i,
  input  l15_adapter_pkg::icache_req_t  icache_req_i,
  input  logic                          dcache_vld_i,
  input  l15_adapter_pkg::dcache_req_t  dcache_req_i,
  input  logic                          l15_ack_i,
  output logic                          icache_pop_o,
  output logic                          dcache_pop_o,
  output l15_adapter_pkg::l15_req_t     l15_req_o
);

  import l15_adapter_pkg::*;

  // index 0 is the icache side, 1 the dcache side
  logic last_q;
  logic lock_q;
  logic lock_idx_q;
  logic grant_idx;
  logic req_vld;

  //////////////////////////////////////////////////
  // grant selection
  //////////////////////////////////////////////////

  assign req_vld = icache_vld_i | dcache_vld_i;

  always_comb begin
    if (lock_q) begin
      // hold the grant until the L1.5 takes it
      grant_idx = lock_idx_q;
    end else if (icache_vld_i && dcache_vld_i) begin
      grant_idx = ~last_q;
    end else begin
      grant_idx = dcache_vld_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // so the first contested grant goes to the icache
      last_q     <= 1'b1;
      lock_q     <= 1'b0;
      lock_idx_q <= 1'b0;
    end else if (req_vld) begin
      if (l15_ack_i) begin
        last_q <= grant_idx;
        lock_q <= 1'b0;
      end else begin
        lock_q     <= 1'b1;
        lock_idx_q <= grant_idx;
      end
    end
  end

  // one-cycle pop of the served queue
  assign icache_pop_o = req_vld & l15_ack_i & ~grant_idx;
  assign dcache_pop_o = req_vld & l15_ack_i & grant_idx;

  //////////////////////////////////////////////////
  // packet encoding
  //////////////////////////////////////////////////

  always_comb begin
    l15_req_o.val  = req_vld;
    // store data always comes from the dcache head, swapped to big endian
    l15_req_o.data = swap_bytes64(dcache_req_i.data);
    if (grant_idx) begin
      l15_req_o.nc      = dcache_req_i.nc;
      l15_req_o.size    = dcache_req_i.size;
      l15_req_o.tid     = dcache_req_i.tid;
      l15_req_o.way     = dcache_req_i.way;
      l15_req_o.address = dcache_req_i.paddr;
      if (dcache_req_i.rtype == dcache_store_req) begin
        l15_req_o.rqtype = l15_store_rq;
      end else begin
        l15_req_o.rqtype = l15_load_rq;
      end
    end else begin
      l15_req_o.rqtype  = l15_imiss_rq;
      l15_req_o.nc      = icache_req_i.nc;
      // nc fills go to io space and return 4 bytes only
      l15_req_o.size    = icache_req_i.nc ? l15_size_4b : l15_size_line;
      l15_req_o.tid     = icache_req_i.tid;
      l15_req_o.way     = icache_req_i.way;
      l15_req_o.address = icache_req_i.paddr;
    end
  end

  // an unacknowledged request stays valid with the same winner
  grant_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (req_vld && !l15_ack_i) |=> (req_vld && grant_idx == $past(grant_idx)))
    else $error("l15_req_arbiter: grant changed before L1.5 ack");

endmodule

/* rtl/l15_rtrn_decoder.sv */
// decoder for L1.5 return packets
// routes to the caches, maps invalidations and swaps data bytes

`timescale 1ns/100ps

module l15_rtrn_decoder (
  input  logic                          rtrn_vld_i,
  input  l15_adapter_pkg::l15_rtrn_t    rtrn_i,
  output logic                          rtrn_pop_o,
  output logic                          icache_rtrn_vld_o,
  output l15_adapter_pkg::icache_rtrn_t icache_rtrn_o,
  output logic                          dcache_rtrn_vld_o,
  output l15_adapter_pkg::dcache_rtrn_t dcache_rtrn_o
);

  import l15_adapter_pkg::*;

  logic [inv_idx_w-1:0] inv_idx;

  // caches take returns at once, so the head leaves every valid cycle
  assign rtrn_pop_o = rtrn_vld_i;

  //////////////////////////////////////////////////
  // payload mapping
  //////////////////////////////////////////////////

  // L1.5 sends address bits 15..4 only
  assign inv_idx = {rtrn_i.inval_address_15_4, 4'b0000};

  assign icache_rtrn_o.tid      = rtrn_i.tid;
  assign icache_rtrn_o.inv.idx  = inv_idx;
  assign icache_rtrn_o.inv.way  = rtrn_i.inval_way;
  assign icache_rtrn_o.inv.vld  = rtrn_i.inval_icache_inval;
  assign icache_rtrn_o.inv.all  = rtrn_i.inval_icache_all_way;

  assign dcache_rtrn_o.tid      = rtrn_i.tid;
  assign dcache_rtrn_o.inv.idx  = inv_idx;
  assign dcache_rtrn_o.inv.way  = rtrn_i.inval_way;
  assign dcache_rtrn_o.inv.vld  = rtrn_i.inval_dcache_inval;
  assign dcache_rtrn_o.inv.all  = rtrn_i.inval_dcache_all_way;

  // each 64-bit word swapped in place, word order kept
  assign icache_rtrn_o.data = {swap_bytes64(rtrn_i.data_3),
                               swap_bytes64(rtrn_i.data_2),
                               swap_bytes64(rtrn_i.data_1),
                               swap_bytes64(rtrn_i.data_0)};
  // dcache sees only the lower two words
  assign dcache_rtrn_o.data = {swap_bytes64(rtrn_i.data_1),
                               swap_bytes64(rtrn_i.data_0)};

  //////////////////////////////////////////////////
  // type decode and strobes
  //////////////////////////////////////////////////

  always_comb begin
    icache_rtrn_o.rtype = icache_ifill_ack;
    dcache_rtrn_o.rtype = dcache_load_ack;
    icache_rtrn_vld_o   = 1'b0;
    dcache_rtrn_vld_o   = 1'b0;
    if (rtrn_vld_i) begin
      case (rtrn_i.returntype)
        l15_load_ret: begin
          dcache_rtrn_vld_o = 1'b1;
        end
        l15_st_ack: begin
          dcache_rtrn_o.rtype = dcache_store_ack;
          dcache_rtrn_vld_o   = 1'b1;
        end
        l15_ifill_ret: begin
          icache_rtrn_vld_o = 1'b1;
        end
        l15_evict_req: begin
          // strobe only the caches named by the flags
          icache_rtrn_o.rtype = icache_inv_req;
          dcache_rtrn_o.rtype = dcache_inv_req;
          icache_rtrn_vld_o   = rtrn_i.inval_icache_inval | rtrn_i.inval_icache_all_way;
          dcache_rtrn_vld_o   = rtrn_i.inval_dcache_inval | rtrn_i.inval_dcache_all_way;
        end
        default: begin
          // unsupported return types are dropped
        end
      endcase
    end
  end

  // an evict packet with no flag would be lost silently
  always_comb begin
    if (rtrn_vld_i && rtrn_i.returntype == l15_evict_req) begin
      evict_has_flag: assert final (rtrn_i.inval_icache_inval | rtrn_i.inval_icache_all_way |
                                    rtrn_i.inval_dcache_inval | rtrn_i.inval_dcache_all_way)
        else $error("l15_rtrn_decoder: evict packet without invalidation flags");
    end
  end

endmodule

/* rtl/l15_adapter.sv */
// top level of the cache to L1.5 adapter
// request queues, arbiter, return queue and return decoder

`timescale 1ns/100ps

module l15_adapter (
  input  logic                          clk_i,
  input  logic                          reset_i,
  // icache
  input  logic                          icache_req_i,
  output logic                          icache_ack_o,
  input  l15_adapter_pkg::icache_req_t  icache_data_i,
  output logic                          icache_rtrn_vld_o,
  output l15_adapter_pkg::icache_rtrn_t icache_rtrn_o,
  // dcache
  input  logic                          dcache_req_i,
  output logic                          dcache_ack_o,
  input  l15_adapter_pkg::dcache_req_t  dcache_data_i,
  output logic                          dcache_rtrn_vld_o,
  output l15_adapter_pkg::dcache_rtrn_t dcache_rtrn_o,
  // L1.5
  output l15_adapter_pkg::l15_req_t     l15_req_o,
  output logic                          l15_req_ack_o,
  input  logic                          l15_ack_i,
  input  l15_adapter_pkg::l15_rtrn_t    l15_rtrn_i
);

  import l15_adapter_pkg::*;

  icache_req_t icache_head;
  logic        icache_full;
  logic        icache_empty;
  logic        icache_pop;
  dcache_req_t dcache_head;
  logic        dcache_full;
  logic        dcache_empty;
  logic        dcache_pop;
  l15_rtrn_t   rtrn_head;
  logic        rtrn_full;
  logic        rtrn_empty;
  logic        rtrn_pop;

  //////////////////////////////////////////////////
  // request path
  //////////////////////////////////////////////////

  // same-cycle ack while the queue has room
  assign icache_ack_o = icache_req_i & ~icache_full;
  assign dcache_ack_o = dcache_req_i & ~dcache_full;

  l15_fifo #(.payload_t(icache_req_t), .depth(req_fifo_depth)) i_icache_fifo (
    .clk_i, .reset_i,
    .push_i  (icache_ack_o),
    .data_i  (icache_data_i),
    .full_o  (icache_full),
    .empty_o (icache_empty),
    .data_o  (icache_head),
    .pop_i   (icache_pop)
  );

  l15_fifo #(.payload_t(dcache_req_t), .depth(req_fifo_depth)) i_dcache_fifo (
    .clk_i, .reset_i,
    .push_i  (dcache_ack_o),
    .data_i  (dcache_data_i),
    .full_o  (dcache_full),
    .empty_o (dcache_empty),
    .data_o  (dcache_head),
    .pop_i   (dcache_pop)
  );

  l15_req_arbiter i_arbiter (
    .clk_i, .reset_i,
    .icache_vld_i (~icache_empty),
    .icache_req_i (icache_head),
    .dcache_vld_i (~dcache_empty),
    .dcache_req_i (dcache_head),
    .l15_ack_i,
    .icache_pop_o (icache_pop),
    .dcache_pop_o (dcache_pop),
    .l15_req_o
  );

  //////////////////////////////////////////////////
  // return path
  //////////////////////////////////////////////////

  // take the packet only if it can be buffered
  assign l15_req_ack_o = l15_rtrn_i.val & ~rtrn_full;

  l15_fifo #(.payload_t(l15_rtrn_t), .depth(rtrn_fifo_depth)) i_rtrn_fifo (
    .clk_i, .reset_i,
    .push_i  (l15_req_ack_o),
    .data_i  (l15_rtrn_i),
    .full_o  (rtrn_full),
    .empty_o (rtrn_empty),
    .data_o  (rtrn_head),
    .pop_i   (rtrn_pop)
  );

  l15_rtrn_decoder i_decoder (
    .rtrn_vld_i (~rtrn_empty),
    .rtrn_i     (rtrn_head),
    .rtrn_pop_o (rtrn_pop),
    .icache_rtrn_vld_o,
    .icache_rtrn_o,
    .dcache_rtrn_vld_o,
    .dcache_rtrn_o
  );

endmodule

/* include/l15_adapter_tb_tasks.svh */
// typed compare tasks, stimulus helpers and directed tests
// for the cache to L1.5 adapter testbench

`ifndef L15_ADAPTER_TB_TASKS_SVH
`define L15_ADAPTER_TB_TASKS_SVH

//////////////////////////////////////////////////
// compares
//////////////////////////////////////////////////

task automatic flag_check(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    abort_run($sformatf("ERR %s expected %0b actual %0b", name, exp, act));
  end
endtask

task automatic req_check(input string name, input l15_req_t exp, input l15_req_t act);
  if (act !== exp) begin
    abort_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
  end
endtask

task automatic icache_rtrn_check(input string name, input icache_rtrn_t exp,
                                 input icache_rtrn_t act);
  if (act !== exp) begin
    abort_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
  end
endtask

task automatic dcache_rtrn_check(input string name, input dcache_rtrn_t exp,
                                 input dcache_rtrn_t act);
  if (act !== exp) begin
    abort_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
  end
endtask

//////////////////////////////////////////////////
// stimulus and expected values
//////////////////////////////////////////////////

function automatic icache_req_t make_icache_req(input logic nc, input logic [1:0] way,
                                                input logic [1:0] tid,
                                                input logic [39:0] paddr);
  icache_req_t r;
  r.nc    = nc;
  r.way   = way;
  r.tid   = tid;
  r.paddr = paddr;
  return r;
endfunction

function automatic dcache_req_t make_dcache_req(input dcache_req_e rtype,
                                                input logic [2:0] size,
                                                input logic [1:0] tid,
                                                input logic [39:0] paddr,
                                                input logic [63:0] data);
  dcache_req_t r;
  r       = '0;
  r.rtype = rtype;
  r.size  = size;
  r.way   = tid + 2'd1;
  r.tid   = tid;
  r.paddr = paddr;
  r.data  = data;
  return r;
endfunction

// imiss, full line unless non-cacheable
function automatic l15_req_t ifill_expect(input icache_req_t r);
  l15_req_t e;
  e         = '0;
  e.val     = 1'b1;
  e.rqtype  = l15_imiss_rq;
  e.nc      = r.nc;
  e.size    = r.nc ? l15_size_4b : l15_size_line;
  e.tid     = r.tid;
  e.way     = r.way;
  e.address = r.paddr;
  return e;
endfunction

// be_data is the store data as the big endian L1.5 must see it
function automatic l15_req_t data_expect(input dcache_req_t r, input logic [63:0] be_data);
  l15_req_t e;
  e         = '0;
  e.val     = 1'b1;
  e.rqtype  = (r.rtype == dcache_store_req) ? l15_store_rq : l15_load_rq;
  e.nc      = r.nc;
  e.size    = r.size;
  e.tid     = r.tid;
  e.way     = r.way;
  e.address = r.paddr;
  e.data    = (r.rtype == dcache_store_req) ? be_data : 64'h0;
  return e;
endfunction

function automatic l15_rtrn_t rtrn_pkt(input l15_rtntype_e rtype, input logic [1:0] tid);
  l15_rtrn_t p;
  p            = '0;
  p.val        = 1'b1;
  p.returntype = rtype;
  p.tid        = tid;
  p.data_0     = rtrn_word0;
  p.data_1     = rtrn_word1;
  p.data_2     = rtrn_word2;
  p.data_3     = rtrn_word3;
  return p;
endfunction

// change the responder hold between edges so it never races the responder
task automatic hold_ack(input logic on);
  @(posedge clk_i);
  ack_hold = on;
endtask

task automatic push_icache(input icache_req_t r);
  @(posedge clk_i);
  icache_req_i  <= 1'b1;
  icache_data_i <= r;
  do @(negedge clk_i); while (!icache_ack_o);
  @(posedge clk_i);
  icache_req_i <= 1'b0;
endtask

task automatic push_dcache(input dcache_req_t r);
  @(posedge clk_i);
  dcache_req_i  <= 1'b1;
  dcache_data_i <= r;
  do @(negedge clk_i); while (!dcache_ack_o);
  @(posedge clk_i);
  dcache_req_i <= 1'b0;
endtask

task automatic take_accepted(output l15_req_t r);
  while (accepted_q.size() == 0) @(negedge clk_i);
  r = accepted_q.pop_front();
endtask

// strobe must follow one cycle after the adapter takes the packet
task automatic send_rtrn(input string name, input l15_rtrn_t pkt,
                         input logic exp_i_vld, input icache_rtrn_t exp_i,
                         input logic exp_d_vld, input dcache_rtrn_t exp_d);
  @(posedge clk_i);
  l15_rtrn_i <= pkt;
  @(negedge clk_i);
  flag_check({name, " ack"}, 1'b1, l15_req_ack_o);
  flag_check({name, " early icache strobe"}, 1'b0, icache_rtrn_vld_o);
  flag_check({name, " early dcache strobe"}, 1'b0, dcache_rtrn_vld_o);
  @(posedge clk_i);
  l15_rtrn_i <= '0;
  @(negedge clk_i);
  flag_check({name, " icache strobe"}, exp_i_vld, icache_rtrn_vld_o);
  flag_check({name, " dcache strobe"}, exp_d_vld, dcache_rtrn_vld_o);
  if (exp_i_vld) begin
    icache_rtrn_check(name, exp_i, icache_rtrn_o);
  end
  if (exp_d_vld) begin
    dcache_rtrn_check(name, exp_d, dcache_rtrn_o);
  end
endtask

//////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////

task automatic ifill_requests();
  icache_req_t ra;
  icache_req_t rb;
  l15_req_t    got;
  ra = make_icache_req(1'b0, 2'd1, 2'd2, 40'h12_3456_7840);
  rb = make_icache_req(1'b1, 2'd3, 2'd1, 40'hf0_0000_1004);
  push_icache(ra);
  take_accepted(got);
  req_check("ifill cacheable", ifill_expect(ra), got);
  push_icache(rb);
  take_accepted(got);
  req_check("ifill noncacheable", ifill_expect(rb), got);
endtask

task automatic data_requests();
  dcache_req_t ld;
  dcache_req_t st;
  l15_req_t    got;
  ld = make_dcache_req(dcache_load_req, 3'b011, 2'd0, 40'h00_8000_0010, rtrn_word1);
  st = make_dcache_req(dcache_store_req, 3'b011, 2'd3, 40'h00_8000_0028, rtrn_word2);
  push_dcache(ld);
  take_accepted(got);
  req_check("data load", data_expect(ld, 64'h0), got);
  push_dcache(st);
  take_accepted(got);
  // little endian store data leaves byte reversed
  req_check("data store", data_expect(st, le_word2), got);
endtask

task automatic round_robin_order();
  icache_req_t ia;
  icache_req_t ib;
  dcache_req_t da;
  dcache_req_t db;
  l15_req_t    exp_q[$];
  l15_req_t    got;
  ia = make_icache_req(1'b0, 2'd0, 2'd0, 40'h01_0000_0000);
  ib = make_icache_req(1'b1, 2'd2, 2'd1, 40'h01_0000_0104);
  da = make_dcache_req(dcache_load_req, 3'b010, 2'd2, 40'h02_0000_0008, rtrn_word3);
  db = make_dcache_req(dcache_store_req, 3'b011, 2'd1, 40'h02_0000_0010, rtrn_word0);
  // the store of the previous test went last, so the icache wins first
  exp_q.push_back(ifill_expect(ia));
  exp_q.push_back(data_expect(da, 64'h0));
  exp_q.push_back(ifill_expect(ib));
  exp_q.push_back(data_expect(db, le_word0));
  hold_ack(1'b1);
  fork
    begin
      push_icache(ia);
      push_icache(ib);
    end
    begin
      push_dcache(da);
      push_dcache(db);
    end
  join
  hold_ack(1'b0);
  for (int n = 0; n < 4; n++) begin
    take_accepted(got);
    req_check($sformatf("round robin %0d", n), exp_q[n], got);
  end
endtask

task automatic request_backpressure();
  dcache_req_t ra;
  dcache_req_t rb;
  dcache_req_t rc;
  l15_req_t    got;
  int unsigned n_before;
  ra = make_dcache_req(dcache_load_req, 3'b001, 2'd0, 40'h03_0000_0000, rtrn_word0);
  rb = make_dcache_req(dcache_load_req, 3'b010, 2'd1, 40'h03_0000_0040, rtrn_word1);
  rc = make_dcache_req(dcache_store_req, 3'b011, 2'd2, 40'h03_0000_0080, rtrn_word3);
  hold_ack(1'b1);
  push_dcache(ra);
  push_dcache(rb);
  // queue is full now, the third request must wait
  @(posedge clk_i);
  dcache_req_i  <= 1'b1;
  dcache_data_i <= rc;
  repeat (4) begin
    @(negedge clk_i);
    flag_check("backpressure full", 1'b0, dcache_ack_o);
  end
  n_before = accepted_q.size();
  hold_ack(1'b0);
  do @(negedge clk_i); while (!dcache_ack_o);
  flag_check("backpressure pop", 1'b1, accepted_q.size() > n_before);
  @(posedge clk_i);
  dcache_req_i <= 1'b0;
  take_accepted(got);
  req_check("backpressure first", data_expect(ra, 64'h0), got);
  take_accepted(got);
  req_check("backpressure second", data_expect(rb, 64'h0), got);
  take_accepted(got);
  req_check("backpressure third", data_expect(rc, le_word3), got);
endtask

task automatic return_routing();
  icache_rtrn_t ei;
  dcache_rtrn_t ed;
  ei       = '0;
  ed       = '0;
  ed.rtype = dcache_load_ack;
  ed.tid   = 2'd1;
  ed.data  = {le_word1, le_word0};
  send_rtrn("load return", rtrn_pkt(l15_load_ret, 2'd1), 1'b0, ei, 1'b1, ed);
  ed.rtype = dcache_store_ack;
  ed.tid   = 2'd2;
  send_rtrn("store ack", rtrn_pkt(l15_st_ack, 2'd2), 1'b0, ei, 1'b1, ed);
  ei.rtype = icache_ifill_ack;
  ei.tid   = 2'd3;
  ei.data  = {le_word3, le_word2, le_word1, le_word0};
  send_rtrn("ifill return", rtrn_pkt(l15_ifill_ret, 2'd3), 1'b1, ei, 1'b0, ed);
endtask

task automatic eviction_routing();
  l15_rtrn_t    pkt;
  icache_rtrn_t ei;
  dcache_rtrn_t ed;
  logic [3:0]   flags;
  for (int c = 0; c < 3; c++) begin
    // icache inval and all-way, dcache inval and all-way
    flags = (c == 0) ? 4'b1000 : ((c == 1) ? 4'b0001 : 4'b0110);
    pkt = rtrn_pkt(l15_evict_req, 2'(c));
    pkt.inval_address_15_4 = 12'habc + 12'(c);
    pkt.inval_way          = 2'd2;
    {pkt.inval_icache_inval, pkt.inval_icache_all_way,
     pkt.inval_dcache_inval, pkt.inval_dcache_all_way} = flags;
    ei.rtype   = icache_inv_req;
    ei.tid     = 2'(c);
    ei.inv.idx = {pkt.inval_address_15_4, 4'b0000};
    ei.inv.way = 2'd2;
    ei.inv.vld = flags[3];
    ei.inv.all = flags[2];
    ei.data    = {le_word3, le_word2, le_word1, le_word0};
    ed.rtype   = dcache_inv_req;
    ed.tid     = 2'(c);
    ed.inv.idx = {pkt.inval_address_15_4, 4'b0000};
    ed.inv.way = 2'd2;
    ed.inv.vld = flags[1];
    ed.inv.all = flags[0];
    ed.data    = {le_word1, le_word0};
    send_rtrn($sformatf("eviction %0d", c), pkt, flags[3] | flags[2], ei,
              flags[1] | flags[0], ed);
  end
endtask

`endif

/* testbench/l15_adapter_tb.sv */
// testbench for the cache to L1.5 adapter
// clock, reset, DUT, L1.5 responder, watchdog and test sequence

`timescale 1ns/100ps

module l15_adapter_tb;

  import l15_adapter_pkg::*;

  // tests need a few hundred cycles even with the longest ack delays
  localparam int unsigned watchdog_cycles = 2000;

  // big endian words as sent by the L1.5, and the same words byte reversed
  localparam logic [63:0] rtrn_word0 = 64'h0011_2233_4455_6677;
  localparam logic [63:0] rtrn_word1 = 64'h8899_aabb_ccdd_eeff;
  localparam logic [63:0] rtrn_word2 = 64'h0123_4567_89ab_cdef;
  localparam logic [63:0] rtrn_word3 = 64'hfedc_ba98_7654_3210;
  localparam logic [63:0] le_word0   = 64'h7766_5544_3322_1100;
  localparam logic [63:0] le_word1   = 64'hffee_ddcc_bbaa_9988;
  localparam logic [63:0] le_word2   = 64'hefcd_ab89_6745_2301;
  localparam logic [63:0] le_word3   = 64'h1032_5476_98ba_dcfe;

  logic         clk_i;
  logic         reset_i;
  logic         icache_req_i;
  logic         icache_ack_o;
  icache_req_t  icache_data_i;
  logic         icache_rtrn_vld_o;
  icache_rtrn_t icache_rtrn_o;
  logic         dcache_req_i;
  logic         dcache_ack_o;
  dcache_req_t  dcache_data_i;
  logic         dcache_rtrn_vld_o;
  dcache_rtrn_t dcache_rtrn_o;
  l15_req_t     l15_req_o;
  logic         l15_req_ack_o;
  logic         l15_ack_i;
  l15_rtrn_t    l15_rtrn_i;

  // responder state
  integer       seed = 32'h7ea6_5155;
  logic         ack_next;
  logic         ack_hold;
  logic         req_pending;
  int unsigned  ack_wait;
  l15_req_t     held_req;
  l15_req_t     accepted_q[$];

  always #2 clk_i = ~clk_i;

  l15_adapter DUT (.*);

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TESTS FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  // store data is the only meaningful data field of a request
  function automatic l15_req_t req_view(input l15_req_t r);
    l15_req_t v;
    v = r;
    if (r.rqtype != l15_store_rq) begin
      v.data = '0;
    end
    return v;
  endfunction

  `include "l15_adapter_tb_tasks.svh"

  //////////////////////////////////////////////////
  // L1.5 responder
  //////////////////////////////////////////////////

  // decides at the falling edge, drives at the rising edge
  always @(negedge clk_i) begin
    if (reset_i) begin
      ack_next    = 1'b0;
      req_pending = 1'b0;
    end else if (l15_req_o.val && l15_ack_i) begin
      // taken at the coming edge
      accepted_q.push_back(req_view(l15_req_o));
      ack_next    = 1'b0;
      req_pending = 1'b0;
    end else if (l15_req_o.val) begin
      if (req_pending) begin
        req_check("grant hold", held_req, req_view(l15_req_o));
      end else begin
        req_pending = 1'b1;
        held_req    = req_view(l15_req_o);
        ack_wait    = $unsigned($random(seed)) % 4;
      end
      if (!ack_hold) begin
        if (ack_wait == 0) begin
          ack_next = 1'b1;
        end else begin
          ack_wait--;
        end
      end
    end else if (req_pending) begin
      abort_run("L1.5 request valid dropped before the acknowledge");
    end
  end

  always @(posedge clk_i) begin
    l15_ack_i <= ack_next;
  end

  //////////////////////////////////////////////////
  // watchdog and sequence
  //////////////////////////////////////////////////

  initial begin
    repeat (watchdog_cycles) @(posedge clk_i);
    abort_run("watchdog expired, the DUT stopped responding");
  end

  initial begin
    clk_i           = 1'b0;
    reset_i         = 1'b1;
    icache_req_i    = 1'b0;
    icache_data_i   = '0;
    dcache_req_i    = 1'b0;
    dcache_data_i   = '0;
    l15_ack_i       = 1'b0;
    l15_rtrn_i      = '0;
    ack_next        = 1'b0;
    ack_hold        = 1'b0;
    req_pending     = 1'b0;
    ack_wait        = 0;
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;
    ifill_requests();
    data_requests();
    round_robin_order();
    request_backpressure();
    return_routing();
    eviction_routing();
    repeat (2) @(posedge clk_i);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* l15_adapter.f */
+incdir+include
rtl/l15_adapter_pkg.sv
rtl/l15_fifo.sv
rtl/l15_req_arbiter.sv
rtl/l15_rtrn_decoder.sv
rtl/l15_adapter.sv
testbench/l15_adapter_tb.sv
